//--- verilog/alu_pkg.sv
package alu_pkg;

    // Datapath widths
    localparam int ALU_W    = 32;
    localparam int OPCODE_W = 5;
    localparam int SHAMT_W  = 5;

    // Supported operations
    // Any other code gives a zero result
    typedef enum logic [OPCODE_W-1:0] {
        OP_ADD = 5'd0,
        OP_SUB = 5'd1,
        OP_AND = 5'd2,
        OP_OR  = 5'd3,
        OP_SLL = 5'd4,
        OP_SRA = 5'd5
    } alu_op_e;

    // Request, 74 bits
    // opcode stays a plain vector so that unused codes can pass through
    typedef struct packed {
        logic [ALU_W-1:0]    op_a;
        logic [ALU_W-1:0]    op_b;
        logic [OPCODE_W-1:0] opcode;
        logic [SHAMT_W-1:0]  shamt;
    } alu_req_t;

    // Response, 35 bits
    typedef struct packed {
        logic [ALU_W-1:0] result;
        logic             not_equal;
        logic             less_than;
        logic             overflow;
    } alu_resp_t;

endpackage

//--- verilog/alu_skid_buffer.sv
`timescale 1ns/10ps

module alu_skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Main entry feeds the output, spare catches an item while main is stuck
    logic     main_valid;
    logic     spare_valid;
    payload_t main_data;
    payload_t spare_data;

    logic     push;
    logic     pop;
    logic     main_free;
    logic     push_to_main;

    assign push = in_valid && in_ready;
    assign pop  = main_valid && out_ready;

    // Main can take a new item when empty or emptying this edge
    assign main_free = pop || !main_valid;

    // An older item in the spare always goes to main first
    assign push_to_main = push && main_free && !spare_valid;

    // Only a full buffer refuses, spare_valid is a flop
    assign in_ready = !spare_valid;

    assign out_valid = main_valid;
    assign out_data  = main_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_free) begin
            main_valid  <= spare_valid || push;
            // Spare moves into main and a push goes straight to main
            spare_valid <= 1'b0;
        end else begin
            spare_valid <= spare_valid || push;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free && spare_valid) begin
            main_data <= spare_data;
        end else if (push_to_main) begin
            main_data <= in_data;
        end

        if (push && !push_to_main) begin
            spare_data <= in_data;
        end
    end

endmodule

//--- verilog/alu_core.sv
`timescale 1ns/10ps

module alu_core
    import alu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      req_valid,
    output logic      req_ready,
    input  alu_req_t  req_payload,

    output logic      resp_valid,
    input  logic      resp_ready,
    output alu_resp_t resp_payload
);

    // Request fields
    logic [ALU_W-1:0]    op_a;
    logic [ALU_W-1:0]    op_b;
    logic [OPCODE_W-1:0] opcode;
    logic [SHAMT_W-1:0]  shamt;

    // Shared add/subtract path
    logic                is_sub;
    logic [ALU_W-1:0]    adder_b;
    logic [ALU_W-1:0]    sum;
    logic                add_ovf;

    // Comparison path
    logic [ALU_W-1:0]    diff;
    logic                signs_differ;

    // Logic and shift results
    logic [ALU_W-1:0]    and_res;
    logic [ALU_W-1:0]    or_res;
    logic [ALU_W-1:0]    sll_res;
    logic [ALU_W-1:0]    sra_res;

    alu_resp_t           next_resp;
    logic                stage_load;

    assign op_a   = req_payload.op_a;
    assign op_b   = req_payload.op_b;
    assign opcode = req_payload.opcode;
    assign shamt  = req_payload.shamt;

    // Subtract is A + ~B + 1 on the same adder
    assign is_sub  = (opcode == OP_SUB);
    assign adder_b = is_sub ? ~op_b : op_b;
    assign sum     = op_a + adder_b + {{(ALU_W-1){1'b0}}, is_sub};

    // Same-sign inputs with a sign change in the sum
    assign add_ovf = (op_a[ALU_W-1] == adder_b[ALU_W-1])
                  && (sum[ALU_W-1] != op_a[ALU_W-1]);

    // Flags ignore the opcode, so the compare keeps its own subtractor
    assign diff         = op_a - op_b;
    assign signs_differ = op_a[ALU_W-1] ^ op_b[ALU_W-1];

    assign and_res = op_a & op_b;
    assign or_res  = op_a | op_b;
    assign sll_res = op_a << shamt;
    // Sign bit of A fills from the top
    assign sra_res = $signed(op_a) >>> shamt;

    always_comb begin
        next_resp.result    = '0;
        next_resp.overflow  = 1'b0;
        next_resp.not_equal = (op_a != op_b);
        // Negative A beats positive B when signs differ
        next_resp.less_than = signs_differ ? op_a[ALU_W-1] : diff[ALU_W-1];

        case (opcode)
            OP_ADD, OP_SUB: begin
                next_resp.result   = sum;
                next_resp.overflow = add_ovf;
            end
            OP_AND: begin
                next_resp.result = and_res;
            end
            OP_OR: begin
                next_resp.result = or_res;
            end
            OP_SLL: begin
                next_resp.result = sll_res;
            end
            OP_SRA: begin
                next_resp.result = sra_res;
            end
            default: begin
                next_resp.result = '0;
            end
        endcase
    end

    // Stage takes a new request when empty or when its response leaves
    assign stage_load = !resp_valid || resp_ready;
    assign req_ready  = stage_load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (stage_load) begin
            resp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_load && req_valid) begin
            resp_payload <= next_resp;
        end
    end

endmodule

//--- verilog/alu_unit.sv
`timescale 1ns/10ps

module alu_unit
    import alu_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    // Request side
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [ALU_W-1:0]    op_a,
    input  logic [ALU_W-1:0]    op_b,
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [SHAMT_W-1:0]  shamt,

    // Response side
    output logic                out_valid,
    input  logic                out_ready,
    output logic [ALU_W-1:0]    result,
    output logic                not_equal,
    output logic                less_than,
    output logic                overflow
);

    alu_req_t  in_req;
    alu_req_t  req_payload;
    logic      req_valid;
    logic      req_ready;

    alu_resp_t resp_payload;
    logic      resp_valid;
    logic      resp_ready;
    alu_resp_t out_resp;

    // Pack the request ports
    assign in_req.op_a   = op_a;
    assign in_req.op_b   = op_b;
    assign in_req.opcode = opcode;
    assign in_req.shamt  = shamt;

    alu_skid_buffer #(
        .payload_t (alu_req_t)
    ) u_req_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_req),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .out_data  (req_payload)
    );

    alu_core u_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_payload  (req_payload),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_payload (resp_payload)
    );

    alu_skid_buffer #(
        .payload_t (alu_resp_t)
    ) u_resp_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (resp_valid),
        .in_ready  (resp_ready),
        .in_data   (resp_payload),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_resp)
    );

    // Unpack the response
    assign result    = out_resp.result;
    assign not_equal = out_resp.not_equal;
    assign less_than = out_resp.less_than;
    assign overflow  = out_resp.overflow;

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 5
) (
    output logic clk
);

    // 10 ns period with the default half period
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

endmodule

//--- tb/alu_checker.sv
`timescale 1ns/10ps

module alu_checker
    import alu_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    input logic             in_valid,
    input logic             in_ready,
    input logic             out_valid,
    input logic             out_ready,
    input logic [ALU_W-1:0] result,
    input logic             not_equal,
    input logic             less_than,
    input logic             overflow,
    input logic             burst_check
);

    // out_valid rises after edge N+2, so a burst response leaves on edge N+3
    localparam int BURST_LATENCY = 3;

    alu_resp_t exp_q[$];
    int        accept_q[$];
    bit        burst_q[$];
    int        edge_count   = 0;
    int        resp_count   = 0;
    int        value_errors = 0;
    int        flow_errors  = 0;
    bit        reset_seen   = 1'b0;

    task automatic push_expected(input alu_resp_t expected);
        exp_q.push_back(expected);
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    task automatic compare_field(input string name, input logic [ALU_W-1:0] expected,
                                 input logic [ALU_W-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s of response %0d expected 0x%0h got 0x%0h",
                     name, resp_count, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_reset_state();
        if (in_ready !== 1'b1) begin
            $display("[FAIL] in_ready after reset expected 0x1 got 0x%0h", in_ready);
            value_errors++;
        end
        if (out_valid !== 1'b0) begin
            $display("[FAIL] out_valid after reset expected 0x0 got 0x%0h", out_valid);
            value_errors++;
        end
    endtask

    task automatic check_response();
        alu_resp_t expected;
        int        accepted;
        bit        in_burst;

        if (exp_q.size() == 0 || accept_q.size() == 0) begin
            $display("Output transfer on edge %0d with no request outstanding",
                     edge_count + 1);
            flow_errors++;
        end else begin
            expected = exp_q.pop_front();
            accepted = accept_q.pop_front();
            in_burst = burst_q.pop_front();
            compare_field("result", expected.result, result);
            compare_field("not_equal", ALU_W'(expected.not_equal), ALU_W'(not_equal));
            compare_field("less_than", ALU_W'(expected.less_than), ALU_W'(less_than));
            compare_field("overflow", ALU_W'(expected.overflow), ALU_W'(overflow));
            if (in_burst && (edge_count - accepted != BURST_LATENCY)) begin
                $display("Burst response %0d left %0d edges after its request instead of %0d",
                         resp_count, edge_count - accepted, BURST_LATENCY);
                flow_errors++;
            end
        end
        resp_count++;
    endtask

    always @(posedge clk) begin
        edge_count++;
    end

    // Sampled mid-cycle, each transfer is seen just before the edge that makes it
    always @(negedge clk) begin
        if (rst_n) begin
            // First cycle out of reset
            if (!reset_seen) begin
                check_reset_state();
                reset_seen = 1'b1;
            end
            if (in_valid && in_ready) begin
                accept_q.push_back(edge_count);
                burst_q.push_back(burst_check);
            end
            if (out_valid && out_ready) begin
                check_response();
            end
        end
    end

endmodule

//--- tb/tb_alu_unit.sv
`timescale 1ns/10ps

module tb_alu_unit
    import alu_pkg::*;
();

    localparam int PH_LIGHT     = 0;
    localparam int PH_HEAVY     = 1;
    localparam int PH_BURST     = 2;
    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 1000;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    logic                in_ready;
    logic [ALU_W-1:0]    op_a;
    logic [ALU_W-1:0]    op_b;
    logic [OPCODE_W-1:0] opcode;
    logic [SHAMT_W-1:0]  shamt;
    logic                out_valid;
    logic                out_ready = 1'b0;
    logic [ALU_W-1:0]    result;
    logic                not_equal;
    logic                less_than;
    logic                overflow;

    int                  out_mode = PH_LIGHT;
    logic                burst_check;
    int                  sent;
    int                  tb_errors;
    int                  timeout_errors;
    bit                  aborted;

    tb_clock_gen u_clock_gen (.clk(clk));

    alu_unit u_alu_unit (.*);

    alu_checker u_checker (.*);

    // Heavy phase stalls 70 percent of cycles, light phase 20 percent
    function automatic logic draw_ready(input int mode);
        int roll;
        roll = int'($urandom % 100);
        if (mode == PH_BURST) begin
            return 1'b1;
        end else if (mode == PH_HEAVY) begin
            return roll >= 70;
        end
        return roll >= 20;
    endfunction

    always @(posedge clk) begin
        #1;
        out_ready = draw_ready(out_mode);
    end

    task automatic send_request(input logic [OPCODE_W-1:0] v_opcode,
                                input logic [SHAMT_W-1:0] v_shamt,
                                input logic [ALU_W-1:0] v_a, input logic [ALU_W-1:0] v_b,
                                input alu_resp_t expected);
        int waited;
        waited = 0;
        u_checker.push_expected(expected);
        @(posedge clk);
        #1;
        op_a     = v_a;
        op_b     = v_b;
        opcode   = v_opcode;
        shamt    = v_shamt;
        in_valid = 1'b1;
        // Transfer happens on the edge after a mid-cycle in_ready
        do begin
            @(negedge clk);
            waited++;
        end while (!in_ready && waited < ACCEPT_LIMIT);
        if (!in_ready) begin
            $display("Timeout: request %0d was not accepted within %0d cycles",
                     sent, ACCEPT_LIMIT);
            timeout_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (u_checker.pending_count() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (u_checker.pending_count() != 0) begin
            $display("Timeout: %0d responses still missing after %0d cycles",
                     u_checker.pending_count(), limit);
            timeout_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic set_phase(input int phase);
        @(posedge clk);
        // New mode applies from the next out_ready draw
        out_mode    = phase;
        #1;
        in_valid    = 1'b0;
        burst_check = 1'b0;
        // A burst starts from an empty pipeline so its latency is exact
        if (phase == PH_BURST) begin
            wait_drain(DRAIN_LIMIT);
            burst_check = 1'b1;
        end
    endtask

    initial begin : stimulus
        int          fd;
        int          fields;
        int          phase;
        int          total;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_sh;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_res;
        logic [31:0] f_ne;
        logic [31:0] f_lt;
        logic [31:0] f_ov;
        alu_resp_t   expected;

        rst_n          = 1'b0;
        in_valid       = 1'b0;
        op_a           = '0;
        op_b           = '0;
        opcode         = '0;
        shamt          = '0;
        burst_check    = 1'b0;
        sent           = 0;
        tb_errors      = 0;
        timeout_errors = 0;
        aborted        = 1'b0;
        void'($urandom(51));

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("tb/alu_input.dat", "r");
        if (fd == 0) begin
            $display("Could not open the data file tb/alu_input.dat");
            tb_errors++;
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                // Blank and comment lines carry no vector
                if (line.len() != 0 && line[0] != "#" && line[0] != "\n") begin
                    if (line[0] == "p") begin
                        if ($sscanf(line, "phase %d", phase) == 1) begin
                            set_phase(phase);
                        end else begin
                            $display("Unreadable phase line in the data file: %s", line);
                            tb_errors++;
                        end
                    end else begin
                        fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                         f_op, f_sh, f_a, f_b, f_res, f_ne, f_lt, f_ov);
                        if (fields != 8) begin
                            $display("Unreadable vector line in the data file: %s", line);
                            tb_errors++;
                        end else begin
                            expected.result    = f_res;
                            expected.not_equal = f_ne[0];
                            expected.less_than = f_lt[0];
                            expected.overflow  = f_ov[0];
                            send_request(f_op[OPCODE_W-1:0], f_sh[SHAMT_W-1:0], f_a, f_b,
                                         expected);
                            sent++;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (!aborted) begin
            wait_drain(DRAIN_LIMIT);
        end
        if (sent == 0) begin
            $display("No vectors were read from the data file");
            tb_errors++;
        end

        total = tb_errors + timeout_errors + u_checker.value_errors + u_checker.flow_errors;
        $display("Errors: %0d value, %0d flow, %0d timeout, %0d setup over %0d vectors",
                 u_checker.value_errors, u_checker.flow_errors, timeout_errors,
                 tb_errors, sent);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- vlog.f
verilog/alu_pkg.sv
verilog/alu_skid_buffer.sv
verilog/alu_core.sv
verilog/alu_unit.sv
tb/tb_clock_gen.sv
tb/alu_checker.sv
tb/tb_alu_unit.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_alu_unit
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/alu_input.dat
# opcode shamt op_a op_b result not_equal less_than overflow, all in hex
# phase N sets out_ready: 0 light back-pressure, 1 heavy, 2 held high for a burst
phase 0
# add
00 00 00000001 00000002 00000003 1 1 0
00 00 7FFFFFFF 00000001 80000000 1 0 1
00 00 FFFFFFFF 00000001 00000000 1 1 0
00 00 80000000 80000000 00000000 0 0 1
00 00 12345678 12345678 2468ACF0 0 0 0
00 00 80000000 FFFFFFFF 7FFFFFFF 1 1 1
# subtract
01 00 80000000 00000001 7FFFFFFF 1 1 1
01 00 00000005 00000003 00000002 1 0 0
01 00 00000003 00000005 FFFFFFFE 1 1 0
01 00 7FFFFFFF FFFFFFFF 80000000 1 0 1
01 00 FFFFFFF0 FFFFFFF0 00000000 0 0 0
01 00 00000000 80000000 80000000 1 0 1
# and, or
02 00 F0F0F0F0 0FF00FF0 00F000F0 1 1 0
02 1F FFFFFFFF 12345678 12345678 1 1 0
03 00 F0F0F0F0 0FF00FF0 FFF0FFF0 1 1 0
03 00 00000000 00000000 00000000 0 0 0
# shift left
04 00 89ABCDEF 00000000 89ABCDEF 1 1 0
04 01 89ABCDEF 00000000 13579BDE 1 1 0
04 1F 00000003 00000003 80000000 0 0 0
04 10 0000ABCD 00000001 ABCD0000 1 0 0
# arithmetic shift right
05 00 80000000 00000000 80000000 1 1 0
05 01 80000000 00000000 C0000000 1 1 0
05 1F 80000000 00000000 FFFFFFFF 1 1 0
05 1F 7FFFFFFF 00000000 00000000 1 0 0
05 04 F0000010 00000000 FF000001 1 1 0
05 01 40000000 7FFFFFFF 20000000 1 1 0
phase 1
# unused opcodes
06 03 12345678 9ABCDEF0 00000000 1 0 0
07 00 7FFFFFFF 00000001 00000000 1 0 0
10 00 00000001 00000002 00000000 1 1 0
1F 1F FFFFFFFF FFFFFFFF 00000000 0 0 0
0F 00 80000000 7FFFFFFF 00000000 1 1 0
1A 05 00000000 00000000 00000000 0 0 0
# same-sign compares under each opcode
00 00 FFFFFFFE FFFFFFFF FFFFFFFD 1 1 0
01 00 FFFFFFFF FFFFFFFE 00000001 1 0 0
02 00 00000010 00000020 00000000 1 1 0
03 00 00000020 00000010 00000030 1 0 0
04 02 80000001 80000002 00000004 1 1 0
05 02 80000002 80000001 E0000000 1 0 0
01 00 55555555 55555555 00000000 0 0 0
00 00 40000000 40000000 80000000 0 0 1
00 00 00001000 FFFFF000 00000000 1 0 0
01 00 FFFFFFFF 7FFFFFFF 80000000 1 1 0
phase 2
# back-to-back burst
00 00 00000010 00000020 00000030 1 1 0
01 00 00000010 00000020 FFFFFFF0 1 1 0
02 00 FFFF0000 00FFFF00 00FF0000 1 1 0
03 00 FFFF0000 00FFFF00 FFFFFF00 1 1 0
04 08 000000AB 00000000 0000AB00 1 0 0
05 08 8000AB00 00000000 FF8000AB 1 1 0
09 00 00000001 00000001 00000000 0 0 0
00 00 FFFFFFFF FFFFFFFF FFFFFFFE 0 0 0
